/* hw/rv_id_pkg.sv */
`default_nettype none

package rv_id_pkg;

	localparam int XLEN    = 32;
	localparam int NUM_SRC = 2; // rs1 and rs2

	typedef logic [XLEN-1:0] word_t;
	typedef logic [XLEN-1:0] inst_t;
	typedef logic [4:0]      reg_addr_t;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// funct3 for OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;

	localparam logic [2:0] F3_JALR = 3'b000;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA/SRAI

	typedef enum logic [4:0] {
		ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
		ALU_SB, ALU_SH, ALU_SW,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
		ALU_JAL, ALU_JALR
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_LOAD_STORE, SEL_JUMP_BRANCH
	} alu_sel_e;

	typedef enum logic [3:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
	} br_kind_e;

	typedef struct packed {
		logic      rd_en;
		reg_addr_t addr;
		word_t     alt;   // operand when rd_en is low
	} src_req_t;

	// write-back seen from a later stage
	typedef struct packed {
		logic      wreg;
		reg_addr_t rd;
		word_t     wdata;
		logic      is_load;
	} fwd_t;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		reg_addr_t rd;
		logic      wreg;
		br_kind_e  br_kind;
		word_t     br_off;
	} dec_ctrl_t;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		word_t     op_a;
		word_t     op_b;
		reg_addr_t rd;
		logic      wreg;
	} id_ex_t;

	typedef struct packed {
		logic  taken;
		word_t target;
		word_t link;
	} br_res_t;

endpackage

`default_nettype wire

/* hw/id_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
	input  rv_id_pkg::inst_t                              inst_i,
	input  rv_id_pkg::word_t                              pc_i,
	output rv_id_pkg::dec_ctrl_t                          ctrl_o,
	output rv_id_pkg::src_req_t [rv_id_pkg::NUM_SRC-1:0] src_o
);
	import rv_id_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	reg_addr_t  rd_field;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	word_t      shamt;
	logic       is_shift;
	logic       f7_ok;
	logic       valid;
	logic       wreg;
	alu_op_e    arith_op;
	alu_op_e    op;
	br_kind_e   br_kind;
	word_t      br_off;

	function automatic alu_sel_e sel_of(alu_op_e a);
		case (a)
			ALU_NOP:                                return SEL_NOP;
			ALU_AND, ALU_OR, ALU_XOR:               return SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA:              return SEL_SHIFT;
			ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU:    return SEL_ARITH;
			ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE,
			ALU_BLTU, ALU_BGEU, ALU_JAL, ALU_JALR:  return SEL_JUMP_BRANCH;
			default:                                return SEL_LOAD_STORE;
		endcase
	endfunction

	assign opcode   = inst_i[6:0];
	assign funct3   = inst_i[14:12];
	assign funct7   = inst_i[31:25];
	assign rs1      = inst_i[19:15];
	assign rs2      = inst_i[24:20];
	assign rd_field = inst_i[11:7];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign shamt = {27'b0, inst_i[24:20]};

	assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);
	// alt funct7 only legal on SRA(I) and SUB
	assign f7_ok = (funct7 == F7_BASE) || ((funct7 == F7_ALT) &&
		((funct3 == F3_SRL_SRA) || (opcode == OPC_OP && funct3 == F3_ADD_SUB)));

	// shared by OP and OP-IMM
	always_comb begin
		case (funct3)
			F3_ADD_SUB: arith_op = (opcode == OPC_OP && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
			F3_SLL:     arith_op = ALU_SLL;
			F3_SLT:     arith_op = ALU_SLT;
			F3_SLTU:    arith_op = ALU_SLTU;
			F3_XOR:     arith_op = ALU_XOR;
			F3_SRL_SRA: arith_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
			F3_OR:      arith_op = ALU_OR;
			F3_AND:     arith_op = ALU_AND;
			default:    arith_op = ALU_NOP;
		endcase
	end

	always_comb begin
		op = ALU_NOP;
		wreg = 1'b0;
		br_kind = BR_NONE;
		br_off = '0;
		valid = 1'b1;
		src_o[0] = '{rd_en: 1'b1, addr: rs1, alt: '0};
		src_o[1] = '{rd_en: 1'b0, addr: rs2, alt: imm_i};
		case (opcode)
			OPC_OP_IMM: begin
				op = arith_op;
				wreg = 1'b1;
				valid = f7_ok || !is_shift;
				if (is_shift)
					src_o[1].alt = shamt;
			end
			OPC_OP: begin
				op = arith_op;
				wreg = 1'b1;
				valid = f7_ok;
				src_o[1].rd_en = 1'b1;
			end
			OPC_LUI: begin
				op = ALU_OR;         // x0 | imm
				wreg = 1'b1;
				src_o[0].addr = '0;
				src_o[1].alt = imm_u;
			end
			OPC_AUIPC: begin
				op = ALU_ADD;
				wreg = 1'b1;
				src_o[0] = '{rd_en: 1'b0, addr: rs1, alt: pc_i};
				src_o[1].alt = imm_u;
			end
			OPC_JAL: begin
				op = ALU_JAL;
				wreg = 1'b1;
				br_kind = BR_JAL;
				br_off = imm_j;
				src_o[0].rd_en = 1'b0;
				src_o[1].alt = imm_j;
			end
			OPC_JALR: begin
				op = ALU_JALR;
				wreg = 1'b1;
				br_kind = BR_JALR;
				br_off = imm_i;     // added to forwarded rs1
				valid = (funct3 == F3_JALR);
			end
			OPC_BRANCH: begin
				br_off = imm_b;
				src_o[1].rd_en = 1'b1;
				case (funct3)
					F3_BEQ:  br_kind = BR_BEQ;
					F3_BNE:  br_kind = BR_BNE;
					F3_BLT:  br_kind = BR_BLT;
					F3_BGE:  br_kind = BR_BGE;
					F3_BLTU: br_kind = BR_BLTU;
					F3_BGEU: br_kind = BR_BGEU;
					default: valid = 1'b0;
				endcase
				case (funct3)
					F3_BEQ:  op = ALU_BEQ;
					F3_BNE:  op = ALU_BNE;
					F3_BLT:  op = ALU_BLT;
					F3_BGE:  op = ALU_BGE;
					F3_BLTU: op = ALU_BLTU;
					default: op = ALU_BGEU;
				endcase
			end
			OPC_LOAD: begin
				wreg = 1'b1;
				case (funct3)
					F3_LB:   op = ALU_LB;
					F3_LH:   op = ALU_LH;
					F3_LW:   op = ALU_LW;
					F3_LBU:  op = ALU_LBU;
					F3_LHU:  op = ALU_LHU;
					default: valid = 1'b0;
				endcase
			end
			OPC_STORE: begin
				src_o[1].rd_en = 1'b1; // store data, offset rides in alt
				src_o[1].alt = imm_s;
				case (funct3)
					F3_SB:   op = ALU_SB;
					F3_SH:   op = ALU_SH;
					F3_SW:   op = ALU_SW;
					default: valid = 1'b0;
				endcase
			end
			default: valid = 1'b0;
		endcase
		// unknown encodings leave as a plain NOP
		if (!valid) begin
			op = ALU_NOP;
			wreg = 1'b0;
			br_kind = BR_NONE;
			br_off = '0;
			src_o[0] = '{rd_en: 1'b0, addr: rs1, alt: '0};
			src_o[1] = '{rd_en: 1'b0, addr: rs2, alt: '0};
		end
	end

	assign ctrl_o = '{
		alu_op:  op,
		alu_sel: sel_of(op),
		rd:      wreg ? rd_field : 5'd0,
		wreg:    wreg,
		br_kind: br_kind,
		br_off:  br_off
	};

endmodule

`default_nettype wire

/* hw/id_operand.sv */
`timescale 1ns/1ps
`default_nettype none

module id_operand (
	input  rv_id_pkg::src_req_t src_i,
	input  rv_id_pkg::word_t    reg_rdata_i,
	input  rv_id_pkg::fwd_t     fwd_ex_i,
	input  rv_id_pkg::fwd_t     fwd_mem_i,
	output rv_id_pkg::word_t    operand_o,
	output logic                load_use_o
);

	logic reads_reg;
	logic ex_hit;
	logic mem_hit;

	// x0 never forwards and never stalls
	assign reads_reg = src_i.rd_en && (src_i.addr != 5'd0);
	assign ex_hit    = fwd_ex_i.wreg && (fwd_ex_i.rd == src_i.addr);
	assign mem_hit   = fwd_mem_i.wreg && (fwd_mem_i.rd == src_i.addr);

	always_comb begin
		if (!src_i.rd_en)
			operand_o = src_i.alt;     // imm or pc
		else if (!reads_reg)
			operand_o = '0;
		else if (ex_hit)
			operand_o = fwd_ex_i.wdata; // youngest wins
		else if (mem_hit)
			operand_o = fwd_mem_i.wdata;
		else
			operand_o = reg_rdata_i;
	end

	// load data not back until after execute
	assign load_use_o = reads_reg && fwd_ex_i.is_load && (fwd_ex_i.rd == src_i.addr);

endmodule

`default_nettype wire

/* hw/id_branch.sv */
`timescale 1ns/1ps
`default_nettype none

module id_branch (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 issue_i,
	input  rv_id_pkg::word_t     pc_i,
	input  rv_id_pkg::dec_ctrl_t ctrl_i,
	input  rv_id_pkg::word_t     op_a_i,
	input  rv_id_pkg::word_t     op_b_i,
	output logic                 ex_strobe_o,
	output rv_id_pkg::id_ex_t    id_ex_o,
	output rv_id_pkg::br_res_t   br_o
);
	import rv_id_pkg::*;

	logic    taken;
	word_t   link;
	word_t   jalr_sum;
	br_res_t br_next;

	always_comb begin
		case (ctrl_i.br_kind)
			BR_BEQ:  taken = (op_a_i == op_b_i);
			BR_BNE:  taken = (op_a_i != op_b_i);
			BR_BLT:  taken = ($signed(op_a_i) < $signed(op_b_i));
			BR_BGE:  taken = ($signed(op_a_i) >= $signed(op_b_i));
			BR_BLTU: taken = (op_a_i < op_b_i);
			BR_BGEU: taken = (op_a_i >= op_b_i);
			BR_JAL,
			BR_JALR: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign link     = pc_i + 32'd4;
	assign jalr_sum = op_a_i + ctrl_i.br_off;

	always_comb begin
		br_next = '0;
		br_next.taken = taken;
		if (ctrl_i.br_kind == BR_JALR) begin
			br_next.target = {jalr_sum[XLEN-1:1], 1'b0};
			br_next.link = link;
		end else if (taken) begin
			br_next.target = pc_i + ctrl_i.br_off; // B or J offset
			if (ctrl_i.br_kind == BR_JAL)
				br_next.link = link;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ex_strobe_o <= 1'b0;
			id_ex_o <= '0;
			br_o <= '0;
		end else begin
			ex_strobe_o <= issue_i; // one-cycle pulse
			if (issue_i) begin
				id_ex_o <= '{
					alu_op:  ctrl_i.alu_op,
					alu_sel: ctrl_i.alu_sel,
					op_a:    op_a_i,
					op_b:    op_b_i,
					rd:      ctrl_i.rd,
					wreg:    ctrl_i.wreg
				};
				br_o <= br_next;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input  logic                                           clk_i,
	input  logic                                           rst_n_i,
	input  logic                                           inst_strobe_i,
	input  rv_id_pkg::inst_t                               inst_i,
	input  rv_id_pkg::word_t                               pc_i,
	output rv_id_pkg::reg_addr_t [rv_id_pkg::NUM_SRC-1:0] reg_raddr_o,
	output logic [rv_id_pkg::NUM_SRC-1:0]                  reg_ren_o,
	input  rv_id_pkg::word_t [rv_id_pkg::NUM_SRC-1:0]     reg_rdata_i,
	input  rv_id_pkg::fwd_t                                fwd_ex_i,
	input  rv_id_pkg::fwd_t                                fwd_mem_i,
	output logic                                           stall_o,
	output logic                                           ex_strobe_o,
	output rv_id_pkg::id_ex_t                              id_ex_o,
	output rv_id_pkg::br_res_t                             br_o
);
	import rv_id_pkg::*;

	dec_ctrl_t              ctrl;
	src_req_t [NUM_SRC-1:0] src_req;
	word_t [NUM_SRC-1:0]    operand;
	logic [NUM_SRC-1:0]     load_use;
	logic                   issue;

	id_decoder i_decoder (
		.inst_i (inst_i),
		.pc_i   (pc_i),
		.ctrl_o (ctrl),
		.src_o  (src_req)
	);

	// source 0 is rs1, source 1 is rs2 or immediate
	for (genvar g = 0; g < NUM_SRC; g++) begin : g_src
		assign reg_raddr_o[g] = src_req[g].addr;
		assign reg_ren_o[g]   = src_req[g].rd_en;

		id_operand i_operand (
			.src_i       (src_req[g]),
			.reg_rdata_i (reg_rdata_i[g]),
			.fwd_ex_i    (fwd_ex_i),
			.fwd_mem_i   (fwd_mem_i),
			.operand_o   (operand[g]),
			.load_use_o  (load_use[g])
		);
	end

	assign stall_o = inst_strobe_i && (|load_use);
	assign issue   = inst_strobe_i && !stall_o; // stalled strobe is dropped

	id_branch i_branch (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.issue_i     (issue),
		.pc_i        (pc_i),
		.ctrl_i      (ctrl),
		.op_a_i      (operand[0]),
		.op_b_i      (operand[1]),
		.ex_strobe_o (ex_strobe_o),
		.id_ex_o     (id_ex_o),
		.br_o        (br_o)
	);

endmodule

`default_nettype wire

/* dv/tb_id_tests.svh */
// instruction words, field layout per the base ISA
function automatic inst_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
	return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic inst_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic inst_t b_type(input word_t off, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic inst_t u_type(input logic [19:0] imm, input reg_addr_t rd,
		input logic [6:0] opc);
	return {imm, rd, opc};
endfunction

function automatic inst_t j_type(input word_t off, input reg_addr_t rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

function automatic fwd_t fwd_entry(input reg_addr_t rd, input word_t data, input logic load);
	return '{wreg: 1'b1, rd: rd, wdata: data, is_load: load};
endfunction

function automatic id_ex_t ex_payload(input alu_op_e op, input alu_sel_e sel, input word_t a,
		input word_t b, input reg_addr_t rd, input logic wreg);
	return '{alu_op: op, alu_sel: sel, op_a: a, op_b: b, rd: rd, wreg: wreg};
endfunction

function automatic br_res_t br_result(input logic taken, input word_t target, input word_t link);
	return '{taken: taken, target: target, link: link};
endfunction

task automatic reset_state();
	int e0 = errors;
	@(negedge clk);
	bit_compare("reset ex_strobe", ex_strobe, 1'b0);
	id_ex_compare("reset", id_ex, '0);
	bit_compare("reset taken", br.taken, 1'b0);
	report_test("reset", e0);
endtask

task automatic alu_ops();
	int e0 = errors;
	issue_and_check(i_type(12'hFFB, 5'd3, F3_ADD_SUB, 5'd5, OPC_OP_IMM), 32'h100, '0, '0, "addi",
		ex_payload(ALU_ADD, SEL_ARITH, regs[3], 32'hFFFF_FFFB, 5'd5, 1'b1), '0, 2'b01);
	issue_and_check(i_type(12'd100, 5'd4, F3_SLTU, 5'd6, OPC_OP_IMM), 32'h104, '0, '0, "sltiu",
		ex_payload(ALU_SLTU, SEL_ARITH, regs[4], 32'd100, 5'd6, 1'b1), '0, 2'b01);
	issue_and_check(i_type(12'h0F0, 5'd8, F3_XOR, 5'd7, OPC_OP_IMM), 32'h108, '0, '0, "xori",
		ex_payload(ALU_XOR, SEL_LOGIC, regs[8], 32'h0F0, 5'd7, 1'b1), '0, 2'b01);
	issue_and_check(i_type({F7_ALT, 5'd7}, 5'd10, F3_SRL_SRA, 5'd9, OPC_OP_IMM), 32'h10C,
		'0, '0, "srai", ex_payload(ALU_SRA, SEL_SHIFT, regs[10], 32'd7, 5'd9, 1'b1), '0,
		2'b01);
	issue_and_check(r_type(F7_BASE, 5'd13, 5'd12, F3_ADD_SUB, 5'd11), 32'h110, '0, '0, "add",
		ex_payload(ALU_ADD, SEL_ARITH, regs[12], regs[13], 5'd11, 1'b1), '0, 2'b11);
	issue_and_check(r_type(F7_ALT, 5'd16, 5'd15, F3_ADD_SUB, 5'd14), 32'h114, '0, '0, "sub",
		ex_payload(ALU_SUB, SEL_ARITH, regs[15], regs[16], 5'd14, 1'b1), '0, 2'b11);
	issue_and_check(r_type(F7_BASE, 5'd19, 5'd18, F3_SRL_SRA, 5'd17), 32'h118, '0, '0, "srl",
		ex_payload(ALU_SRL, SEL_SHIFT, regs[18], regs[19], 5'd17, 1'b1), '0, 2'b11);
	report_test("alu", e0);
endtask

task automatic upper_imms();
	int e0 = errors;
	// rs1 bits of lui hold immediate bits but operand a must still be zero
	issue_and_check(u_type(20'h12345, 5'd20, OPC_LUI), 32'h200, '0, '0, "lui",
		ex_payload(ALU_OR, SEL_LOGIC, '0, 32'h1234_5000, 5'd20, 1'b1), '0, 2'b01);
	issue_and_check(u_type(20'hFEDCB, 5'd21, OPC_AUIPC), 32'h2000, '0, '0, "auipc",
		ex_payload(ALU_ADD, SEL_ARITH, 32'h2000, 32'hFEDC_B000, 5'd21, 1'b1), '0, 2'b00);
	report_test("upper", e0);
endtask

task automatic fwd_priority();
	int e0 = errors;
	inst_t add_x22 = r_type(F7_BASE, 5'd24, 5'd22, F3_ADD_SUB, 5'd23);
	issue_and_check(add_x22, 32'h300, fwd_entry(5'd22, 32'hAAAA_0001, 1'b0),
		fwd_entry(5'd22, 32'hBBBB_0002, 1'b0), "fwd ex",
		ex_payload(ALU_ADD, SEL_ARITH, 32'hAAAA_0001, regs[24], 5'd23, 1'b1), '0, 2'b11);
	issue_and_check(add_x22, 32'h304, fwd_entry(5'd9, 32'hAAAA_0001, 1'b0),
		fwd_entry(5'd22, 32'hBBBB_0002, 1'b0), "fwd mem",
		ex_payload(ALU_ADD, SEL_ARITH, 32'hBBBB_0002, regs[24], 5'd23, 1'b1), '0, 2'b11);
	issue_and_check(r_type(F7_BASE, 5'd24, 5'd0, F3_ADD_SUB, 5'd23), 32'h308,
		fwd_entry(5'd0, 32'hAAAA_0001, 1'b0), fwd_entry(5'd0, 32'hBBBB_0002, 1'b0), "fwd x0",
		ex_payload(ALU_ADD, SEL_ARITH, '0, regs[24], 5'd23, 1'b1), '0, 2'b11);
	report_test("forward", e0);
endtask

task automatic load_use_stall();
	int e0 = errors;
	inst_t add_x27 = r_type(F7_BASE, 5'd27, 5'd26, F3_ADD_SUB, 5'd25);
	drive_inst(add_x27, 32'h400, fwd_entry(5'd27, 32'h0, 1'b1), '0, 1'b1, 2'b11,
		"load-use");
	// load now in memory stage and its data forwards
	issue_and_check(add_x27, 32'h400, '0, fwd_entry(5'd27, 32'h5A5A_1234, 1'b1), "replay",
		ex_payload(ALU_ADD, SEL_ARITH, regs[26], 32'h5A5A_1234, 5'd25, 1'b1), '0, 2'b11);
	report_test("stall", e0);
endtask

task automatic cond_branches();
	int        e0 = errors;
	logic [2:0] f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
	alu_op_e   op [6] = '{ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};
	// even entries hold the condition and odd entries break it
	int        ra [12] = '{1, 1, 1, 1, 3, 1, 1, 3, 1, 3, 3, 1};
	int        rb [12] = '{2, 4, 4, 2, 1, 3, 3, 1, 3, 1, 1, 3};
	word_t     pc_b = 32'h0000_1000;
	word_t     off;
	br_res_t   exp_b;
	regs[1] = 32'd5;
	regs[2] = 32'd5;
	regs[3] = 32'hFFFF_FFFD; // -3 is large when unsigned
	regs[4] = 32'd7;
	for (int i = 0; i < 12; i++) begin
		off = word_t'(8 * (i / 2) - 20);
		if (i % 2 == 0)
			exp_b = br_result(1'b1, pc_b + off, '0);
		else
			exp_b = br_result(1'b0, '0, '0);
		issue_and_check(b_type(off, reg_addr_t'(rb[i]), reg_addr_t'(ra[i]), f3[i / 2]), pc_b,
			'0, '0, $sformatf("branch %0d", i), ex_payload(op[i / 2], SEL_JUMP_BRANCH,
			regs[ra[i]], regs[rb[i]], 5'd0, 1'b0), exp_b, 2'b11);
	end
	report_test("branch", e0);
endtask

task automatic jumps();
	int e0 = errors;
	issue_and_check(j_type(32'h1234, 5'd5), 32'h3000, '0, '0, "jal",
		ex_payload(ALU_JAL, SEL_JUMP_BRANCH, '0, 32'h1234, 5'd5, 1'b1),
		br_result(1'b1, 32'h4234, 32'h3004), 2'b00);
	// 0x4010 - 7 is odd so bit 0 drops
	issue_and_check(i_type(12'hFF9, 5'd7, F3_JALR, 5'd6, OPC_JALR), 32'h3100,
		fwd_entry(5'd7, 32'h4010, 1'b0), '0, "jalr",
		ex_payload(ALU_JALR, SEL_JUMP_BRANCH, 32'h4010, 32'hFFFF_FFF9, 5'd6, 1'b1),
		br_result(1'b1, 32'h4008, 32'h3104), 2'b01);
	report_test("jump", e0);
endtask

/* dv/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
	import rv_id_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	// reset check plus two cycles for each of the 28 instructions
	localparam int TEST_CYCLES  = RESET_CYCLES + 1 + 2 * 28;

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic                   inst_strobe;
	inst_t                  inst;
	word_t                  pc;
	reg_addr_t [NUM_SRC-1:0] reg_raddr;
	logic [NUM_SRC-1:0]     reg_ren;
	word_t [NUM_SRC-1:0]    reg_rdata;
	fwd_t                   fwd_ex;
	fwd_t                   fwd_mem;
	logic                   stall;
	logic                   ex_strobe;
	id_ex_t                 id_ex;
	br_res_t                br;

	word_t regs [32];
	int    seed;
	int    errors = 0;
	int    checks = 0;
	int    tests = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	// register file where x0 reads zero
	always_comb begin
		for (int s = 0; s < NUM_SRC; s++)
			reg_rdata[s] = (reg_raddr[s] == 5'd0) ? '0 : regs[reg_raddr[s]];
	end

	id_stage i_dut (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.inst_strobe_i (inst_strobe),
		.inst_i        (inst),
		.pc_i          (pc),
		.reg_raddr_o   (reg_raddr),
		.reg_ren_o     (reg_ren),
		.reg_rdata_i   (reg_rdata),
		.fwd_ex_i      (fwd_ex),
		.fwd_mem_i     (fwd_mem),
		.stall_o       (stall),
		.ex_strobe_o   (ex_strobe),
		.id_ex_o       (id_ex),
		.br_o          (br)
	);

	task automatic bit_compare(input string tag, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %b expected %b", $time, tag, got, exp);
		end
	endtask

	task automatic ren_compare(input string tag, input logic [NUM_SRC-1:0] got,
			input logic [NUM_SRC-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %b expected %b", $time, tag, got, exp);
		end
	endtask

	task automatic id_ex_compare(input string tag, input id_ex_t got, input id_ex_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s id_ex got %h expected %h", $time, tag, got, exp);
		end
	endtask

	task automatic br_compare(input string tag, input br_res_t got, input br_res_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s br got %h expected %h", $time, tag, got, exp);
		end
	endtask

	// one strobe with stall and read enables sampled in its cycle and ex_strobe a cycle later
	task automatic drive_inst(input inst_t ins, input word_t at_pc, input fwd_t ex_fw,
			input fwd_t mem_fw, input logic exp_stall, input logic [NUM_SRC-1:0] exp_ren,
			input string tag);
		@(posedge clk);
		inst_strobe <= 1'b1;
		inst <= ins;
		pc <= at_pc;
		fwd_ex <= ex_fw;
		fwd_mem <= mem_fw;
		@(negedge clk);
		bit_compare({tag, " stall"}, stall, exp_stall);
		ren_compare({tag, " reg_ren"}, reg_ren, exp_ren);
		bit_compare({tag, " early ex_strobe"}, ex_strobe, 1'b0);
		@(posedge clk);
		inst_strobe <= 1'b0;
		fwd_ex <= '0;
		fwd_mem <= '0;
		@(negedge clk);
		bit_compare({tag, " ex_strobe"}, ex_strobe, !exp_stall);
	endtask

	task automatic issue_and_check(input inst_t ins, input word_t at_pc, input fwd_t ex_fw,
			input fwd_t mem_fw, input string tag, input id_ex_t ex_exp, input br_res_t br_exp,
			input logic [NUM_SRC-1:0] exp_ren);
		drive_inst(ins, at_pc, ex_fw, mem_fw, 1'b0, exp_ren, tag);
		id_ex_compare(tag, id_ex, ex_exp);
		br_compare(tag, br, br_exp);
	endtask

	task automatic report_test(input string name, input int err_at_start);
		tests++;
		if (errors == err_at_start)
			$display("test %-10s ok", name);
		else
			$display("test %-10s %0d errors", name, errors - err_at_start);
	endtask

	`include "tb_id_tests.svh"

	initial begin
		rst_n = 1'b0;
		inst_strobe = 1'b0;
		inst = '0;
		pc = '0;
		fwd_ex = '0;
		fwd_mem = '0;
		seed = 17;
		for (int i = 0; i < 32; i++)
			regs[i] = $random(seed);
		regs[0] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		reset_state();
		alu_ops();
		upper_imms();
		fwd_priority();
		load_use_stall();
		cond_branches();
		jumps();
		$display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// generous margin over the test length
	initial begin
		#(4 * TEST_CYCLES * CLK_PERIOD);
		$display("timeout, tests still running after %0d cycles", 4 * TEST_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+dv
hw/rv_id_pkg.sv
hw/id_decoder.sv
hw/id_operand.sv
hw/id_branch.sv
hw/id_stage.sv
dv/tb_id_stage.sv

/* Makefile */
# Verilator flow for the ID stage testbench
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
